//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rv_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
	import rv_core_pkg::*;

	localparam int NUM_TESTS = 8;
	localparam int ISS_LIMIT = 300;

	logic                 clk;
	logic                 rst_n;
	logic                 imem_req_o;
	logic [XLEN-1:0]      imem_addr_o;
	logic                 imem_ack_i;
	logic [31:0]          imem_rdata_i;
	logic                 retire_valid_o;
	retire_t              retire_o;
	logic                 halted_o;
	logic                 trap_o;

	logic [31:0]          mem [256];
	logic [31:0]          lfsr;
	logic [1:0]           ack_delay;
	retire_t              exp_q [$];
	string                test_name;
	bit                   running;
	int                   cyc;
	int                   limit;

	rv_core uut (
		.clk            (clk),
		.rst_n          (rst_n),
		.imem_req_o     (imem_req_o),
		.imem_addr_o    (imem_addr_o),
		.imem_ack_i     (imem_ack_i),
		.imem_rdata_i   (imem_rdata_i),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o),
		.halted_o       (halted_o),
		.trap_o         (trap_o)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return r;
	endfunction

	function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b, input logic alt);
		case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'b0, $signed(a) < $signed(b)};
		3'd3: return {31'b0, a < b};
		3'd4: return a ^ b;
		3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
		endcase
	endfunction

	// Reference ISS that fills exp_q and returns the step count or -1 on a runaway program
	function automatic int run_iss(input int n, output bit trapped);
		logic [31:0] x [32];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] nxt;
		logic [31:0] val;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immi;
		logic [31:0] immb;
		logic [31:0] immj;
		logic [4:0]  rdn;
		logic        take;
		retire_t     rec;
		exp_q.delete();
		for (int i = 0; i < 32; i++) begin
			x[i] = '0;
		end
		pc = RESET_VECTOR;
		trapped = 1'b0;
		for (int steps = 0; steps < ISS_LIMIT; steps++) begin
			if (pc >= 32'(n * 4)) return -1;
			w = mem[pc[9:2]];
			a = x[w[19:15]];
			b = x[w[24:20]];
			immi = {{20{w[31]}}, w[31:20]};
			immb = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			immj = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			nxt = pc + 32'd4;
			val = '0;
			rdn = w[11:7];
			case (w[6:0])
			7'h37: val = {w[31:12], 12'b0};
			7'h17: val = pc + {w[31:12], 12'b0};
			7'h6f: begin
				val = pc + 32'd4;
				nxt = pc + immj;
			end
			7'h67: begin
				val = pc + 32'd4;
				nxt = (a + immi) & ~32'h1;
			end
			7'h63: begin
				rdn = '0;
				case (w[14:12])
				3'd0: take = a == b;
				3'd1: take = a != b;
				3'd4: take = $signed(a) < $signed(b);
				3'd5: take = $signed(a) >= $signed(b);
				3'd6: take = a < b;
				default: take = a >= b;
				endcase
				if (take) nxt = pc + immb;
			end
			7'h13: val = ref_alu(w[14:12], a, immi, w[14:12] == 3'd5 && w[30]);
			7'h33: begin
				if (w[31:25] == 7'h01) begin
					trapped = 1'b1;
					return steps;
				end
				val = ref_alu(w[14:12], a, b, w[30]);
			end
			7'h73: return steps;
			default: begin
				trapped = 1'b1;
				return steps;
			end
			endcase
			if (rdn == '0) val = '0;
			else x[rdn] = val;
			rec.pc = pc;
			rec.rd = rdn;
			rec.wdata = val;
			exp_q.push_back(rec);
			pc = nxt;
		end
		return -1;
	endfunction

	task automatic build_program(input bit use_trap, output int n, output int steps,
		output bit trapped);
		int          tgt;
		logic [31:0] off;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [19:0] u20;
		for (int attempt = 0; attempt < 200; attempt++) begin
			// Unused words decode as invalid and differ per address
			for (int i = 0; i < 256; i++) begin
				mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i), 8'hff};
			end
			n = 20 + int'(rand_bits(4));
			for (int i = 0; i < n - 1; i++) begin
				rd = 5'(rand_bits(3));
				rs1 = 5'(rand_bits(3));
				rs2 = 5'(rand_bits(3));
				f3 = 3'(rand_bits(3));
				case (rand_bits(3))
				0, 1: begin
					imm = 12'(rand_bits(12));
					if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
					if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
					mem[i] = {imm, rs1, f3, rd, 7'h13};
				end
				2: mem[i] = {((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) ? 7'h20 : 7'h00,
					rs2, rs1, f3, rd, 7'h33};
				3: begin
					u20 = 20'(rand_bits(20));
					mem[i] = {u20, rd, rand_bits(1) != 0 ? 7'h37 : 7'h17};
				end
				4: begin
					tgt = i + 1 + int'(rand_bits(8)) % (n - 1 - i);
					off = 32'((tgt - i) * 4);
					mem[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
				end
				5: begin
					// Bit 0 of the target is sometimes set and must be cleared
					tgt = i + 1 + int'(rand_bits(8)) % (n - 1 - i);
					imm = 12'(tgt * 4) | 12'(rand_bits(1));
					mem[i] = {imm, 5'd0, 3'd0, rd, 7'h67};
				end
				default: begin
					tgt = int'(rand_bits(8)) % n;
					if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
					off = 32'((tgt - i) * 4);
					mem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
				end
				endcase
			end
			mem[n - 1] = use_trap ? {7'h01, rs2, rs1, 3'd0, rd, 7'h33} : 32'h0000_0073;
			steps = run_iss(n, trapped);
			if (steps >= 0) return;
		end
		fail_run("could not generate a program that terminates");
	endtask

	// Four-phase memory with a random ack delay
	always @(posedge clk) begin
		if (!rst_n) begin
			imem_ack_i <= 1'b0;
			ack_delay <= 2'(rand_bits(2));
		end else if (imem_req_o && !imem_ack_i) begin
			if (ack_delay == 0) begin
				imem_ack_i <= 1'b1;
				imem_rdata_i <= mem[imem_addr_o[9:2]];
			end else begin
				ack_delay <= ack_delay - 2'd1;
			end
		end else if (!imem_req_o && imem_ack_i) begin
			imem_ack_i <= 1'b0;
			ack_delay <= 2'(rand_bits(2));
		end
	end

	// Compare each retire with the next ISS record
	always @(negedge clk) begin
		retire_t exp;
		if (rst_n && retire_valid_o) begin
			assert (exp_q.size() != 0)
			else fail_run($sformatf("%s: retire at pc %h beyond the ISS trace",
				test_name, retire_o.pc));
			exp = exp_q.pop_front();
			assert (retire_o == exp)
			else fail_run($sformatf(
				"mismatch %s expected pc=%h x%0d=%h actual pc=%h x%0d=%h",
				test_name, exp.pc, exp.rd, exp.wdata,
				retire_o.pc, retire_o.rd, retire_o.wdata));
		end
	end

	always @(negedge clk) begin
		if (running) begin
			cyc = cyc + 1;
			assert (cyc <= limit)
			else fail_run($sformatf("%s: core never halted within %0d cycles",
				test_name, limit));
		end
	end

	task automatic run_test(input int t);
		int  n;
		int  steps;
		bit  trapped;
		bit  prev_req;
		test_name = $sformatf("test%0d_%s", t, t % 2 ? "trap" : "ecall");
		build_program(t % 2 == 1, n, steps, trapped);
		@(posedge clk);
		rst_n <= 1'b0;
		limit = n * (steps + 1) * 8 + 1000;
		cyc = 0;
		running = 1'b1;
		repeat (15) @(posedge clk);
		@(negedge clk);
		assert (!retire_valid_o && !halted_o && !trap_o && !imem_req_o)
		else fail_run($sformatf("%s: outputs not low during reset", test_name));
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		while (!imem_req_o) @(negedge clk);
		assert (imem_addr_o == RESET_VECTOR)
		else fail_run($sformatf("mismatch %s expected addr=%h actual addr=%h",
			test_name, RESET_VECTOR, imem_addr_o));
		while (!halted_o && !trap_o) @(negedge clk);
		assert (halted_o == !trapped && trap_o == trapped)
		else fail_run($sformatf("mismatch %s expected trap=%0d actual halted=%0d trap=%0d",
			test_name, trapped, halted_o, trap_o));
		prev_req = imem_req_o;
		repeat (12) begin
			@(negedge clk);
			assert (!imem_req_o || prev_req)
			else fail_run($sformatf("%s: new instruction request after the core stopped",
				test_name));
			prev_req = imem_req_o;
		end
		assert (exp_q.size() == 0)
		else fail_run($sformatf("mismatch %s expected remaining=0 actual remaining=%0d",
			test_name, exp_q.size()));
		running = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		imem_ack_i = 1'b0;
		imem_rdata_i = '0;
		lfsr = 32'hc7d2_58df;
		running = 1'b0;
		cyc = 0;
		limit = 0;
		test_name = "reset";
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/rv_core_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_pipe_ctrl.sv
verilog/rv_core.sv
dv/tb_rv_core.sv

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  wire                            clk,
	input  wire                            rst_n,
	output logic                           imem_req_o,
	output logic [rv_core_pkg::XLEN-1:0]   imem_addr_o,
	input  wire                            imem_ack_i,
	input  wire  [31:0]                    imem_rdata_i,
	output logic                           retire_valid_o,
	output rv_core_pkg::retire_t           retire_o,
	output logic                           halted_o,
	output logic                           trap_o
);
	import rv_core_pkg::*;

	fd_instr_t         fd;
	logic              decode_take;
	redirect_t         d_jump;
	redirect_t         x_redirect;
	redirect_t         f_redirect;
	logic              x_halt;
	logic              x_trap;
	logic              flush_d_x;
	logic              run;
	dx_ctrl_t          dx;
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   rs1_data;
	logic [XLEN-1:0]   rs2_data;
	logic [XLEN-1:0]   wdata;
	logic              we;

	rv_fetch u_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.imem_req_o   (imem_req_o),
		.imem_addr_o  (imem_addr_o),
		.imem_ack_i   (imem_ack_i),
		.imem_rdata_i (imem_rdata_i),
		.redirect_i   (f_redirect),
		.run_i        (run),
		.take_i       (decode_take),
		.fd_o         (fd)
	);

	rv_decode u_decode (
		.clk     (clk),
		.rst_n   (rst_n),
		.fd_i    (fd),
		.take_o  (decode_take),
		.flush_i (flush_d_x),
		.run_i   (run),
		.jump_o  (d_jump),
		.dx_o    (dx)
	);

	rv_regfile u_regfile (
		.clk        (clk),
		.rst_n      (rst_n),
		.rs1_i      (rs1),
		.rs2_i      (rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.we_i       (we),
		.rd_i       (rd),
		.wdata_i    (wdata)
	);

	rv_execute u_execute (
		.clk            (clk),
		.rst_n          (rst_n),
		.dx_i           (dx),
		.rs1_o          (rs1),
		.rs2_o          (rs2),
		.rs1_data_i     (rs1_data),
		.rs2_data_i     (rs2_data),
		.we_o           (we),
		.rd_o           (rd),
		.wdata_o        (wdata),
		.redirect_o     (x_redirect),
		.halt_o         (x_halt),
		.trap_o         (x_trap),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o)
	);

	rv_pipe_ctrl u_pipe_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.d_jump_i     (d_jump),
		.x_redirect_i (x_redirect),
		.x_halt_i     (x_halt),
		.x_trap_i     (x_trap),
		.f_redirect_o (f_redirect),
		.flush_d_x_o  (flush_d_x),
		.run_o        (run),
		.halted_o     (halted_o),
		.trap_o       (trap_o)
	);

endmodule

`default_nettype wire

//--- verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
	localparam int XLEN = 32;
	localparam int REG_AW = 5;

	// Major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_IMM    = 7'b0010011,
		OPC_REG    = 7'b0110011,
		OPC_FENCE  = 7'b0001111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_GE,
		ALU_GEU
	} alu_op_e;

	typedef enum logic [1:0] {
		SRCA_RS1,
		SRCA_PC,
		SRCA_LINK
	} alu_src_a_e;

	typedef enum logic {
		SRCB_RS2,
		SRCB_IMM
	} alu_src_b_e;

	// Condition applied to the ALU result
	typedef enum logic [1:0] {
		BCOND_NEVER,
		BCOND_ZERO,
		BCOND_NZERO,
		BCOND_ALWAYS
	} bcond_e;

	typedef enum logic [1:0] {
		ST_RUN,
		ST_HALTED,
		ST_TRAPPED
	} core_state_e;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [31:0]     instr;
	} fd_instr_t;

	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   imm;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rd;
		alu_op_e           alu_op;
		alu_src_a_e        src_a;
		alu_src_b_e        src_b;
		bcond_e            bcond;
		logic              jump_is_regoffs;
		logic              pred_taken;
		// Path not chosen by the static prediction
		logic [XLEN-1:0]   alt_addr;
		logic              is_system;
		logic              invalid;
	} dx_ctrl_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic [XLEN-1:0]   pc;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0]   wdata;
	} retire_t;

endpackage

`default_nettype wire

//--- verilog/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  rv_core_pkg::fd_instr_t   fd_i,
	output logic                           take_o,
	input  wire                            flush_i,
	input  wire                            run_i,
	output rv_core_pkg::redirect_t         jump_o,
	output rv_core_pkg::dx_ctrl_t          dx_o
);
	import rv_core_pkg::*;

	logic [31:0]     instr;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic            issue;
	dx_ctrl_t        d_ctrl;
	dx_ctrl_t        dx_q;

	// Shared funct3 mapping of OP and OP-IMM
	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
		3'b000: return alt ? ALU_SUB : ALU_ADD;
		3'b001: return ALU_SLL;
		3'b010: return ALU_SLT;
		3'b011: return ALU_SLTU;
		3'b100: return ALU_XOR;
		3'b101: return alt ? ALU_SRA : ALU_SRL;
		3'b110: return ALU_OR;
		default: return ALU_AND;
		endcase
	endfunction

	assign instr = fd_i.instr;
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign issue = fd_i.valid && run_i && !flush_i;
	assign take_o = issue;

	always_comb begin
		d_ctrl = '0;
		d_ctrl.valid = 1'b1;
		d_ctrl.pc = fd_i.pc;
		d_ctrl.imm = imm_i;
		d_ctrl.rs1 = instr[19:15];
		d_ctrl.rs2 = instr[24:20];
		d_ctrl.rd = instr[11:7];
		d_ctrl.alu_op = ALU_ADD;
		d_ctrl.src_a = SRCA_RS1;
		d_ctrl.src_b = SRCB_RS2;
		d_ctrl.bcond = BCOND_NEVER;
		d_ctrl.alt_addr = fd_i.pc + XLEN'(4);

		case (opcode_e'(instr[6:0]))
		OPC_LUI, OPC_AUIPC: begin
			d_ctrl.imm = imm_u;
			d_ctrl.src_b = SRCB_IMM;
			d_ctrl.src_a = instr[5] ? SRCA_RS1 : SRCA_PC;
			d_ctrl.rs1 = '0;
			d_ctrl.rs2 = '0;
		end
		OPC_JAL: begin
			// Link value comes out as pc+4 plus x0
			d_ctrl.imm = imm_j;
			d_ctrl.src_a = SRCA_LINK;
			d_ctrl.rs1 = '0;
			d_ctrl.rs2 = '0;
			d_ctrl.bcond = BCOND_ALWAYS;
			d_ctrl.pred_taken = 1'b1;
		end
		OPC_JALR: begin
			d_ctrl.src_a = SRCA_LINK;
			d_ctrl.rs2 = '0;
			d_ctrl.jump_is_regoffs = 1'b1;
			d_ctrl.invalid = funct3 != 3'b000;
		end
		OPC_BRANCH: begin
			// Backward branches are predicted taken
			d_ctrl.imm = imm_b;
			d_ctrl.rd = '0;
			d_ctrl.bcond = BCOND_NZERO;
			d_ctrl.pred_taken = imm_b[XLEN-1];
			d_ctrl.alt_addr = imm_b[XLEN-1] ? fd_i.pc + XLEN'(4) : fd_i.pc + imm_b;
			case (funct3)
			3'b000: begin
				d_ctrl.alu_op = ALU_SUB;
				d_ctrl.bcond = BCOND_ZERO;
			end
			3'b001: d_ctrl.alu_op = ALU_SUB;
			3'b100: d_ctrl.alu_op = ALU_SLT;
			3'b101: d_ctrl.alu_op = ALU_GE;
			3'b110: d_ctrl.alu_op = ALU_SLTU;
			3'b111: d_ctrl.alu_op = ALU_GEU;
			default: d_ctrl.invalid = 1'b1;
			endcase
		end
		OPC_IMM: begin
			d_ctrl.src_b = SRCB_IMM;
			d_ctrl.rs2 = '0;
			d_ctrl.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && instr[30]);
			d_ctrl.invalid = (funct3 == 3'b001 && funct7 != 7'b0) ||
				(funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0);
		end
		OPC_REG: begin
			d_ctrl.alu_op = alu_from_funct3(funct3, instr[30]);
			d_ctrl.invalid = !(funct7 == 7'b0 ||
				(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
		end
		OPC_FENCE: begin
			d_ctrl.rd = '0;
			d_ctrl.rs1 = '0;
			d_ctrl.rs2 = '0;
		end
		OPC_SYSTEM: begin
			// ECALL and EBREAK halt the core and any other SYSTEM word traps
			d_ctrl.rd = '0;
			d_ctrl.is_system = instr == 32'h0000_0073 || instr == 32'h0010_0073;
			d_ctrl.invalid = !d_ctrl.is_system;
		end
		default: d_ctrl.invalid = 1'b1;
		endcase

		if (d_ctrl.invalid) begin
			d_ctrl.rd = '0;
			d_ctrl.bcond = BCOND_NEVER;
			d_ctrl.pred_taken = 1'b0;
			d_ctrl.jump_is_regoffs = 1'b0;
			d_ctrl.is_system = 1'b0;
		end
	end

	assign jump_o.valid = issue && d_ctrl.pred_taken;
	assign jump_o.target = fd_i.pc + d_ctrl.imm;

	// Starved or flushed cycles load an all-zero bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_q <= '0;
		end else if (issue) begin
			dx_q <= d_ctrl;
		end else begin
			dx_q <= '0;
		end
	end

	assign dx_o = dx_q;

endmodule

`default_nettype wire

//--- verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire  rv_core_pkg::dx_ctrl_t      dx_i,
	output logic [rv_core_pkg::REG_AW-1:0]   rs1_o,
	output logic [rv_core_pkg::REG_AW-1:0]   rs2_o,
	input  wire  [rv_core_pkg::XLEN-1:0]     rs1_data_i,
	input  wire  [rv_core_pkg::XLEN-1:0]     rs2_data_i,
	output logic                             we_o,
	output logic [rv_core_pkg::REG_AW-1:0]   rd_o,
	output logic [rv_core_pkg::XLEN-1:0]     wdata_o,
	output rv_core_pkg::redirect_t           redirect_o,
	output logic                             halt_o,
	output logic                             trap_o,
	output logic                             retire_valid_o,
	output rv_core_pkg::retire_t             retire_o
);
	import rv_core_pkg::*;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] jalr_sum;
	logic            taken;
	logic            commit;

	always_comb begin
		case (dx_i.src_a)
		SRCA_PC: op_a = dx_i.pc;
		SRCA_LINK: op_a = dx_i.pc + XLEN'(4);
		default: op_a = rs1_data_i;
		endcase
		op_b = dx_i.src_b == SRCB_IMM ? dx_i.imm : rs2_data_i;
	end

	always_comb begin
		case (dx_i.alu_op)
		ALU_SUB: result = op_a - op_b;
		ALU_SLL: result = op_a << op_b[4:0];
		ALU_SLT: result = XLEN'($signed(op_a) < $signed(op_b));
		ALU_SLTU: result = XLEN'(op_a < op_b);
		ALU_XOR: result = op_a ^ op_b;
		ALU_SRL: result = op_a >> op_b[4:0];
		ALU_SRA: result = $unsigned($signed(op_a) >>> op_b[4:0]);
		ALU_OR: result = op_a | op_b;
		ALU_AND: result = op_a & op_b;
		ALU_GE: result = XLEN'($signed(op_a) >= $signed(op_b));
		ALU_GEU: result = XLEN'(op_a >= op_b);
		default: result = op_a + op_b;
		endcase
	end

	always_comb begin
		case (dx_i.bcond)
		BCOND_ZERO: taken = result == '0;
		BCOND_NZERO: taken = result != '0;
		BCOND_ALWAYS: taken = 1'b1;
		default: taken = 1'b0;
		endcase
	end

	assign jalr_sum = rs1_data_i + dx_i.imm;
	assign commit = dx_i.valid && !dx_i.invalid && !dx_i.is_system;

	// Mispredict goes to the other path and JALR always to its computed target
	assign redirect_o.valid = !dx_i.invalid &&
		(dx_i.jump_is_regoffs || taken != dx_i.pred_taken);
	assign redirect_o.target = dx_i.jump_is_regoffs ? {jalr_sum[XLEN-1:1], 1'b0} :
		dx_i.alt_addr;

	assign rs1_o = dx_i.rs1;
	assign rs2_o = dx_i.rs2;
	assign we_o = commit;
	assign rd_o = dx_i.rd;
	assign wdata_o = result;
	assign halt_o = dx_i.valid && dx_i.is_system;
	assign trap_o = dx_i.valid && dx_i.invalid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid_o <= 1'b0;
		end else begin
			retire_valid_o <= commit;
		end
	end

	// Retire shows the value that landed in rd and zero for x0
	always_ff @(posedge clk) begin
		if (commit) begin
			retire_o.pc <= dx_i.pc;
			retire_o.rd <= dx_i.rd;
			retire_o.wdata <= dx_i.rd == '0 ? '0 : result;
		end
	end

	// A bubble from decode never redirects
	assert property (@(posedge clk) disable iff (!rst_n)
		redirect_o.valid |-> dx_i.valid);

	// Wrong-path instruction in decode never reaches execute
	assert property (@(posedge clk) disable iff (!rst_n)
		redirect_o.valid |=> !dx_i.valid);

endmodule

`default_nettype wire

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
	input  wire                            clk,
	input  wire                            rst_n,
	output logic                           imem_req_o,
	output logic [rv_core_pkg::XLEN-1:0]   imem_addr_o,
	input  wire                            imem_ack_i,
	input  wire  [31:0]                    imem_rdata_i,
	input  wire  rv_core_pkg::redirect_t   redirect_i,
	input  wire                            run_i,
	input  wire                            take_i,
	output rv_core_pkg::fd_instr_t         fd_o
);
	import rv_core_pkg::*;

	typedef enum logic [1:0] {
		F_IDLE,
		F_WAIT_ACK,
		F_WAIT_LOW
	} fetch_state_e;

	fetch_state_e    state_q;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] addr_q;
	logic            discard_q;
	logic            buf_valid_q;
	logic [XLEN-1:0] buf_pc_q;
	logic [31:0]     buf_instr_q;
	logic            start;
	logic            capture;

	// New request only when the buffer will be free at ack time
	assign start = state_q == F_IDLE && run_i && !redirect_i.valid &&
		(!buf_valid_q || take_i);
	// A word for a superseded PC is dropped here
	assign capture = state_q == F_WAIT_ACK && imem_ack_i && !discard_q &&
		!redirect_i.valid;

	assign imem_req_o = state_q == F_WAIT_ACK;
	assign imem_addr_o = addr_q;
	assign fd_o = '{valid: buf_valid_q, pc: buf_pc_q, instr: buf_instr_q};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= F_IDLE;
			pc_q <= RESET_VECTOR;
			discard_q <= 1'b0;
			buf_valid_q <= 1'b0;
		end else begin
			if (redirect_i.valid) begin
				pc_q <= redirect_i.target;
			end else if (start) begin
				pc_q <= pc_q + XLEN'(4);
			end

			case (state_q)
			F_IDLE: begin
				if (start) begin
					state_q <= F_WAIT_ACK;
					discard_q <= 1'b0;
				end
			end
			F_WAIT_ACK: begin
				if (imem_ack_i) begin
					state_q <= F_WAIT_LOW;
				end else if (redirect_i.valid) begin
					discard_q <= 1'b1;
				end
			end
			default: begin
				// four-phase return to zero
				if (!imem_ack_i) begin
					state_q <= F_IDLE;
				end
			end
			endcase

			if (redirect_i.valid) begin
				buf_valid_q <= 1'b0;
			end else if (capture) begin
				buf_valid_q <= 1'b1;
			end else if (take_i) begin
				buf_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= pc_q;
		end
		if (capture) begin
			buf_pc_q <= addr_q;
			buf_instr_q <= imem_rdata_i;
		end
	end

	// Request and address hold until the memory answers
	assert property (@(posedge clk) disable iff (!rst_n)
		imem_req_o && !imem_ack_i |=> imem_req_o && $stable(imem_addr_o));

endmodule

`default_nettype wire

//--- verilog/rv_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_ctrl (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  rv_core_pkg::redirect_t   d_jump_i,
	input  wire  rv_core_pkg::redirect_t   x_redirect_i,
	input  wire                            x_halt_i,
	input  wire                            x_trap_i,
	output rv_core_pkg::redirect_t         f_redirect_o,
	output logic                           flush_d_x_o,
	output logic                           run_o,
	output logic                           halted_o,
	output logic                           trap_o
);
	import rv_core_pkg::*;

	core_state_e state_q;

	// HALTED and TRAPPED are left only by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_RUN;
		end else if (state_q == ST_RUN) begin
			if (x_trap_i) begin
				state_q <= ST_TRAPPED;
			end else if (x_halt_i) begin
				state_q <= ST_HALTED;
			end
		end
	end

	// Stop fetch and decode already in the cycle the stop is seen
	assign run_o = state_q == ST_RUN && !x_halt_i && !x_trap_i;

	// Execute redirect beats the decode jump
	always_comb begin
		if (x_redirect_i.valid) begin
			f_redirect_o = x_redirect_i;
		end else begin
			f_redirect_o = d_jump_i;
		end
	end

	assign flush_d_x_o = x_redirect_i.valid;
	assign halted_o = state_q == ST_HALTED;
	assign trap_o = state_q == ST_TRAPPED;

	assert property (@(posedge clk) disable iff (!rst_n)
		state_q != ST_RUN |-> !f_redirect_o.valid);

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  wire                              clk,
	input  wire                              rst_n,
	input  wire  [rv_core_pkg::REG_AW-1:0]   rs1_i,
	input  wire  [rv_core_pkg::REG_AW-1:0]   rs2_i,
	output logic [rv_core_pkg::XLEN-1:0]     rs1_data_o,
	output logic [rv_core_pkg::XLEN-1:0]     rs2_data_o,
	input  wire                              we_i,
	input  wire  [rv_core_pkg::REG_AW-1:0]   rd_i,
	input  wire  [rv_core_pkg::XLEN-1:0]     wdata_i
);
	import rv_core_pkg::*;

	// x0 has no storage
	logic [XLEN-1:0] regs_q [1:31];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && rd_i != '0) begin
			regs_q[rd_i] <= wdata_i;
		end
	end

	assign rs1_data_o = rs1_i == '0 ? '0 : regs_q[rs1_i];
	assign rs2_data_o = rs2_i == '0 ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire
